//--- alu.sv
//****************************************
// 32-bit ALU with zero and signed less-than
// flags for the branch logic
//****************************************

`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_isa_pkg::word_t      i_a,
    input  rv_isa_pkg::word_t      i_b,
    input  rv_ctrl_pkg::alu_ctrl_e i_ctrl,
    output rv_isa_pkg::word_t      o_y,
    output logic                   o_zero,
    output logic                   o_lt
);

    assign o_lt = $signed(i_a) < $signed(i_b);

    always_comb begin
        case (i_ctrl)
            rv_ctrl_pkg::ALU_ADD: o_y = i_a + i_b;
            rv_ctrl_pkg::ALU_SUB: o_y = i_a - i_b;
            rv_ctrl_pkg::ALU_AND: o_y = i_a & i_b;
            rv_ctrl_pkg::ALU_OR:  o_y = i_a | i_b;
            rv_ctrl_pkg::ALU_XOR: o_y = i_a ^ i_b;
            rv_ctrl_pkg::ALU_SLT: o_y = {31'b0, o_lt};
            rv_ctrl_pkg::ALU_SLL: o_y = i_a << i_b[4:0];   // Shift amount 0..31
            rv_ctrl_pkg::ALU_SRL: o_y = i_a >> i_b[4:0];   // Logical
            default:              o_y = '0;
        endcase
    end

    assign o_zero = (o_y == '0);

endmodule

`default_nettype wire

//--- aludec.sv
//****************************************
// ALU decoder. Picks the ALU function from
// the operation class, funct3 and funct7[5]
//****************************************

`timescale 1ns/1ps
`default_nettype none

module aludec (
    input  rv_ctrl_pkg::alu_op_e   i_alu_op,
    input  rv_isa_pkg::funct3_t    i_funct3,
    input  logic                   i_funct7b5,
    input  logic                   i_op5,       // Set for R-type
    output rv_ctrl_pkg::alu_ctrl_e o_alu_ctrl
);

    always_comb begin
        o_alu_ctrl = rv_ctrl_pkg::ALU_ADD;
        case (i_alu_op)
            rv_ctrl_pkg::AOP_ADD: o_alu_ctrl = rv_ctrl_pkg::ALU_ADD;   // Address calc
            rv_ctrl_pkg::AOP_BRANCH: begin
                if (i_funct3 == rv_isa_pkg::F3_BLT || i_funct3 == rv_isa_pkg::F3_BGE)
                    o_alu_ctrl = rv_ctrl_pkg::ALU_SLT;
                else
                    o_alu_ctrl = rv_ctrl_pkg::ALU_SUB;                 // beq/bne
            end
            rv_ctrl_pkg::AOP_FUNC: begin
                case (i_funct3)
                    3'b000:  o_alu_ctrl = (i_funct7b5 & i_op5) ? rv_ctrl_pkg::ALU_SUB
                                                                : rv_ctrl_pkg::ALU_ADD;
                    3'b001:  o_alu_ctrl = rv_ctrl_pkg::ALU_SLL;
                    3'b010:  o_alu_ctrl = rv_ctrl_pkg::ALU_SLT;
                    3'b100:  o_alu_ctrl = rv_ctrl_pkg::ALU_XOR;
                    3'b101:  o_alu_ctrl = rv_ctrl_pkg::ALU_SRL;
                    3'b110:  o_alu_ctrl = rv_ctrl_pkg::ALU_OR;
                    3'b111:  o_alu_ctrl = rv_ctrl_pkg::ALU_AND;
                    default: o_alu_ctrl = rv_ctrl_pkg::ALU_ADD;        // sltu unsupported
                endcase
            end
            default: o_alu_ctrl = rv_ctrl_pkg::ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

//--- controller.sv
//****************************************
// Control unit. Runs both decoders on the
// current instruction and resolves the
// branch into the PC select
//****************************************

`timescale 1ns/1ps
`default_nettype none

module controller (
    input  rv_isa_pkg::word_t  i_instr,
    input  logic               i_alu_zero,
    input  logic               i_alu_lt,
    output rv_ctrl_pkg::ctrl_t o_ctrl
);

    rv_isa_pkg::opcode_e    op;
    rv_isa_pkg::funct3_t    funct3;
    logic                   funct7b5;
    rv_ctrl_pkg::ctrl_t     ctrl_main;
    rv_ctrl_pkg::alu_op_e   alu_op;
    rv_ctrl_pkg::alu_ctrl_e alu_ctrl;
    logic                   cond_met;

    assign op       = rv_isa_pkg::opcode_e'(i_instr[6:0]);
    assign funct3   = i_instr[14:12];
    assign funct7b5 = i_instr[30];

    maindec u_maindec (.i_op(op), .i_funct3(funct3), .o_ctrl_main(ctrl_main), .o_alu_op(alu_op));

    aludec u_aludec (
        .i_alu_op  (alu_op),
        .i_funct3  (funct3),
        .i_funct7b5(funct7b5),
        .i_op5     (i_instr[5]),
        .o_alu_ctrl(alu_ctrl)
    );

    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_BEQ: cond_met = i_alu_zero;
            rv_isa_pkg::F3_BNE: cond_met = ~i_alu_zero;
            rv_isa_pkg::F3_BLT: cond_met = i_alu_lt;      // Signed compare
            rv_isa_pkg::F3_BGE: cond_met = ~i_alu_lt;
            default:            cond_met = 1'b0;
        endcase
    end

    always_comb begin
        o_ctrl          = ctrl_main;
        o_ctrl.alu_ctrl = alu_ctrl;
        o_ctrl.pc_src   = ctrl_main.jump | (ctrl_main.branch & cond_met);
    end

endmodule

`default_nettype wire

//--- datapath.sv
//****************************************
// Datapath of the single-cycle core. PC,
// immediates, register file, ALU, result
// mux and byte-lane alignment of the data
// memory port
//****************************************

`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter rv_isa_pkg::word_t RESET_PC = '0
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  rv_ctrl_pkg::ctrl_t i_ctrl,
    input  rv_isa_pkg::word_t  i_instr,
    input  rv_isa_pkg::word_t  i_dmem_rdata,
    output rv_isa_pkg::word_t  o_pc,
    output rv_isa_pkg::word_t  o_dmem_addr,
    output rv_isa_pkg::word_t  o_dmem_wdata,
    output logic [3:0]         o_dmem_be,
    output logic               o_dmem_we,
    output logic               o_alu_zero,
    output logic               o_alu_lt
);

    rv_isa_pkg::word_t pc, pc_plus4, pc_target, imm_ext;
    rv_isa_pkg::word_t rd1, rd2, src_b, alu_y, load_data, result;
    logic [7:0]        ld_byte;
    logic [15:0]       ld_half;
    logic [1:0]        byte_off;

    always_ff @(posedge i_clk) begin
        if (i_rst) pc <= RESET_PC;
        else       pc <= i_ctrl.pc_src ? pc_target : pc_plus4;
    end

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm_ext;      // Branch and jal target

    always_comb begin
        case (i_ctrl.imm_src)
            rv_ctrl_pkg::IMM_I: imm_ext = {{20{i_instr[31]}}, i_instr[31:20]};
            rv_ctrl_pkg::IMM_S: imm_ext = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            rv_ctrl_pkg::IMM_B: imm_ext = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                                           i_instr[11:8], 1'b0};
            default:            imm_ext = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                                           i_instr[30:21], 1'b0};   // J-type
        endcase
    end

    regfile u_regfile (
        .i_clk(i_clk), .i_rst(i_rst), .i_we(i_ctrl.reg_write),
        .i_ra1(i_instr[19:15]), .i_ra2(i_instr[24:20]), .i_wa(i_instr[11:7]),
        .i_wd(result), .o_rd1(rd1), .o_rd2(rd2)
    );

    assign src_b = i_ctrl.alu_src ? imm_ext : rd2;

    alu u_alu (.i_a(rd1), .i_b(src_b), .i_ctrl(i_ctrl.alu_ctrl),
               .o_y(alu_y), .o_zero(o_alu_zero), .o_lt(o_alu_lt));

    assign byte_off = alu_y[1:0];

    // Store lanes and byte enables
    always_comb begin
        case (i_ctrl.mem_size[1:0])
            2'b00: begin
                o_dmem_wdata = {4{rd2[7:0]}};
                o_dmem_be    = 4'b0001 << byte_off;
            end
            2'b01: begin
                o_dmem_wdata = {2{rd2[15:0]}};
                o_dmem_be    = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                o_dmem_wdata = rd2;
                o_dmem_be    = 4'b1111;
            end
        endcase
    end

    // Load lane select and extension
    assign ld_byte = i_dmem_rdata[{byte_off, 3'b000} +: 8];
    assign ld_half = i_dmem_rdata[{byte_off[1], 4'b0000} +: 16];

    always_comb begin
        case (i_ctrl.mem_size[1:0])
            2'b00:   load_data = i_ctrl.mem_size[2] ? {24'b0, ld_byte}
                                                    : {{24{ld_byte[7]}}, ld_byte};
            2'b01:   load_data = i_ctrl.mem_size[2] ? {16'b0, ld_half}
                                                    : {{16{ld_half[15]}}, ld_half};
            default: load_data = i_dmem_rdata;
        endcase
    end

    always_comb begin
        case (i_ctrl.result_src)
            rv_ctrl_pkg::RES_MEM: result = load_data;
            rv_ctrl_pkg::RES_PC4: result = pc_plus4;    // jal link
            default:              result = alu_y;
        endcase
    end

    assign o_pc        = pc;
    assign o_dmem_addr = alu_y;
    assign o_dmem_we   = i_ctrl.mem_write & ~i_rst;     // No stores during reset

endmodule

`default_nettype wire

//--- files.f
rv_isa_pkg.sv
rv_ctrl_pkg.sv
maindec.sv
aludec.sv
controller.sv
regfile.sv
alu.sv
datapath.sv
riscv_single.sv
tb_riscv_single.sv

//--- maindec.sv
//****************************************
// Main control decoder. Maps the opcode to
// the primary control fields and the ALU
// operation class. Used by the controller
//****************************************

`timescale 1ns/1ps
`default_nettype none

module maindec (
    input  rv_isa_pkg::opcode_e  i_op,        // Opcode field
    input  rv_isa_pkg::funct3_t  i_funct3,    // Memory width for loads/stores
    output rv_ctrl_pkg::ctrl_t   o_ctrl_main, // alu_ctrl and pc_src left zero
    output rv_ctrl_pkg::alu_op_e o_alu_op
);

    always_comb begin
        // Defaults give a no-op
        o_ctrl_main.reg_write  = 1'b0;
        o_ctrl_main.imm_src    = rv_ctrl_pkg::IMM_I;
        o_ctrl_main.alu_src    = 1'b0;
        o_ctrl_main.mem_write  = 1'b0;
        o_ctrl_main.result_src = rv_ctrl_pkg::RES_ALU;
        o_ctrl_main.branch     = 1'b0;
        o_ctrl_main.jump       = 1'b0;
        o_ctrl_main.alu_ctrl   = rv_ctrl_pkg::ALU_ADD;  // Filled in by aludec
        o_ctrl_main.mem_size   = 3'b010;                // Word
        o_ctrl_main.pc_src     = 1'b0;                  // Resolved in controller
        o_alu_op               = rv_ctrl_pkg::AOP_ADD;

        case (i_op)
            rv_isa_pkg::OP_LOAD: begin
                o_ctrl_main.reg_write  = 1'b1;
                o_ctrl_main.alu_src    = 1'b1;          // base + imm
                o_ctrl_main.result_src = rv_ctrl_pkg::RES_MEM;
                o_ctrl_main.mem_size   = i_funct3;
            end
            rv_isa_pkg::OP_STORE: begin
                o_ctrl_main.imm_src   = rv_ctrl_pkg::IMM_S;
                o_ctrl_main.alu_src   = 1'b1;
                o_ctrl_main.mem_write = 1'b1;
                o_ctrl_main.mem_size  = i_funct3;       // sb/sh/sw
            end
            rv_isa_pkg::OP_RTYPE: begin
                o_ctrl_main.reg_write = 1'b1;
                o_alu_op              = rv_ctrl_pkg::AOP_FUNC;
            end
            rv_isa_pkg::OP_ITYPE: begin
                o_ctrl_main.reg_write = 1'b1;
                o_ctrl_main.alu_src   = 1'b1;
                o_alu_op              = rv_ctrl_pkg::AOP_FUNC;
            end
            rv_isa_pkg::OP_BRANCH: begin
                o_ctrl_main.imm_src = rv_ctrl_pkg::IMM_B;
                o_ctrl_main.branch  = 1'b1;
                o_alu_op            = rv_ctrl_pkg::AOP_BRANCH;  // Compare rs1, rs2
            end
            rv_isa_pkg::OP_JAL: begin
                o_ctrl_main.reg_write  = 1'b1;
                o_ctrl_main.imm_src    = rv_ctrl_pkg::IMM_J;
                o_ctrl_main.result_src = rv_ctrl_pkg::RES_PC4;  // Link address
                o_ctrl_main.jump       = 1'b1;
            end
            default: begin
                // Unsupported opcode keeps the no-op defaults
            end
        endcase
    end

endmodule

`default_nettype wire

//--- regfile.sv
//****************************************
// 32 x 32 register file. Two combinational
// read ports, one write port on the clock
//****************************************

`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_we,
    input  rv_isa_pkg::reg_addr_t i_ra1,
    input  rv_isa_pkg::reg_addr_t i_ra2,
    input  rv_isa_pkg::reg_addr_t i_wa,
    input  rv_isa_pkg::word_t     i_wd,
    output rv_isa_pkg::word_t     o_rd1,
    output rv_isa_pkg::word_t     o_rd2
);

    rv_isa_pkg::word_t regs [32];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;  // Clear, no write
        end else if (i_we && i_wa != '0) begin
            regs[i_wa] <= i_wd;
        end
    end

    // x0 hardwired to zero
    assign o_rd1 = (i_ra1 == '0) ? '0 : regs[i_ra1];
    assign o_rd2 = (i_ra2 == '0) ? '0 : regs[i_ra2];

endmodule

`default_nettype wire

//--- riscv_single.sv
//****************************************
// Single-cycle RV32I core top level. Joins
// controller and datapath. Instruction and
// data memories sit outside on the ports
//****************************************

`timescale 1ns/1ps
`default_nettype none

module riscv_single #(
    parameter rv_isa_pkg::word_t RESET_PC = '0
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  rv_isa_pkg::word_t i_instr,       // Word at o_pc, same cycle
    input  rv_isa_pkg::word_t i_dmem_rdata,  // Load data, same cycle
    output rv_isa_pkg::word_t o_pc,
    output rv_isa_pkg::word_t o_dmem_addr,
    output rv_isa_pkg::word_t o_dmem_wdata,
    output logic [3:0]        o_dmem_be,
    output logic              o_dmem_we
);

    rv_ctrl_pkg::ctrl_t ctrl;
    logic               alu_zero;
    logic               alu_lt;

    controller u_controller (
        .i_instr   (i_instr),
        .i_alu_zero(alu_zero),
        .i_alu_lt  (alu_lt),
        .o_ctrl    (ctrl)
    );

    datapath #(.RESET_PC(RESET_PC)) u_datapath (
        .i_clk(i_clk), .i_rst(i_rst), .i_ctrl(ctrl),
        .i_instr(i_instr), .i_dmem_rdata(i_dmem_rdata),
        .o_pc(o_pc), .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata),
        .o_dmem_be(o_dmem_be), .o_dmem_we(o_dmem_we),
        .o_alu_zero(alu_zero), .o_alu_lt(alu_lt)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the single-cycle core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary -f files.f --top-module tb_riscv_single -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
exit 1

//--- rv_ctrl_pkg.sv
//****************************************
// Control encodings of the core. Enums for
// the mux selects and ALU functions, and
// the control struct that the controller
// hands to the datapath
//****************************************

`default_nettype none

package rv_ctrl_pkg;

    typedef enum logic [1:0] {RES_ALU = 2'b00, RES_MEM = 2'b01, RES_PC4 = 2'b10} result_src_e;

    typedef enum logic [1:0] {IMM_I = 2'b00, IMM_S = 2'b01, IMM_B = 2'b10, IMM_J = 2'b11} imm_src_e;

    // Operation class from the main decoder
    typedef enum logic [1:0] {AOP_ADD = 2'b00, AOP_BRANCH = 2'b01, AOP_FUNC = 2'b10} alu_op_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_ctrl_e;

    // Memory funct3: [1:0] width (byte, half, word), [2] unsigned load
    typedef logic [2:0] mem_size_t;

    typedef struct packed {
        logic        reg_write;     // Register file write enable
        imm_src_e    imm_src;       // Immediate format
        logic        alu_src;       // ALU operand B from immediate
        logic        mem_write;     // Data memory write
        result_src_e result_src;    // Writeback source
        logic        branch;
        logic        jump;
        alu_ctrl_e   alu_ctrl;
        mem_size_t   mem_size;
        logic        pc_src;        // Take branch/jump target
    } ctrl_t;

endpackage

`default_nettype wire

//--- rv_isa_pkg.sv
//****************************************
// Instruction set definitions for the RV32I
// subset. Word, register index and funct3
// types plus the supported opcodes. Pulled
// in with rv_isa_pkg:: scoped names
//****************************************

`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;        // Data or address word
    typedef logic [4:0]  reg_addr_t;    // Register index x0..x31
    typedef logic [2:0]  funct3_t;      // Instruction funct3 field

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_RTYPE  = 7'b0110011,
        OP_ITYPE  = 7'b0010011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // Branch conditions
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_BLT = 3'b100;
    localparam funct3_t F3_BGE = 3'b101;

endpackage

`default_nettype wire

//--- tb_riscv_single.sv
//****************************************
// Testbench for the single-cycle core. A
// table of instructions and expected port
// values is stepped one row per cycle
// while load data comes from an LFSR
//****************************************

`timescale 1ns/1ps
`default_nettype none

module tb_riscv_single;

    typedef struct packed {
        rv_isa_pkg::word_t instr;      // Word on the instruction port
        rv_isa_pkg::word_t pc;         // Expected o_pc
        logic              we;         // Expected write strobe
        rv_isa_pkg::word_t addr;       // Expected address, stores and loads
        rv_isa_pkg::word_t wdata;      // Expected store data
        logic [3:0]        be;
        logic              from_load;  // Store data comes from the last load
    } row_t;

    localparam logic [6:0] OPI = rv_isa_pkg::OP_ITYPE;
    localparam logic [6:0] OPL = rv_isa_pkg::OP_LOAD;
    localparam logic [2:0] F3_B = 3'b000, F3_H = 3'b001, F3_W = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100, F3_HU = 3'b101;

    logic              i_clk = 1'b0;
    logic              i_rst;
    rv_isa_pkg::word_t i_instr, i_dmem_rdata;
    rv_isa_pkg::word_t o_pc, o_dmem_addr, o_dmem_wdata;
    logic [3:0]        o_dmem_be;
    logic              o_dmem_we;

    row_t              tbl [$];
    bit                table_ready = 1'b0;
    int                errors = 0;
    logic [31:0]       lfsr = 32'hb07c;
    rv_isa_pkg::word_t rd_word, ld_word, exp_wdata;
    logic [2:0]        ld_f3;
    logic [1:0]        ld_off;
    logic              is_load;

    riscv_single #(.RESET_PC(32'h0)) UUT (
        .i_clk(i_clk), .i_rst(i_rst), .i_instr(i_instr), .i_dmem_rdata(i_dmem_rdata),
        .o_pc(o_pc), .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata),
        .o_dmem_be(o_dmem_be), .o_dmem_we(o_dmem_we)
    );

    always #50 i_clk = ~i_clk;     // 100 ns period

    // Galois LFSR step over one bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_word(output rv_isa_pkg::word_t w);
        w = 32'h0;
        for (int b = 0; b < 32; b++) begin
            w    = {w[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Instruction encoders in assembly operand order
    function automatic rv_isa_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                                input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic rv_isa_pkg::word_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                                input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic rv_isa_pkg::word_t enc_s(input logic [2:0] f3, input int rs2,
                                                input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv_isa_pkg::word_t enc_b(input logic [2:0] f3, input int rs1,
                                                input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv_isa_pkg::word_t enc_j(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // Lane pick by byte offset then sign or zero extension per funct3
    function automatic rv_isa_pkg::word_t extend_load(input rv_isa_pkg::word_t raw,
                                                      input logic [2:0] f3,
                                                      input logic [1:0] off);
        rv_isa_pkg::word_t lane;
        lane = raw >> (8 * off);
        case (f3)
            F3_B:    return {{24{lane[7]}}, lane[7:0]};
            F3_H:    return {{16{lane[15]}}, lane[15:0]};
            F3_BU:   return {24'h0, lane[7:0]};
            F3_HU:   return {16'h0, lane[15:0]};
            default: return raw;
        endcase
    endfunction

    task automatic add_row(input rv_isa_pkg::word_t instr, input rv_isa_pkg::word_t pc,
                           input logic we, input rv_isa_pkg::word_t addr,
                           input rv_isa_pkg::word_t wdata, input logic [3:0] be,
                           input logic from_load);
        tbl.push_back('{instr, pc, we, addr, wdata, be, from_load});
    endtask

    task automatic check_word(input string name, input rv_isa_pkg::word_t act,
                              input rv_isa_pkg::word_t exp);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s = %h, expected %h", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic check_be(input string name, input logic [3:0] act, input logic [3:0] exp);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s = %b, expected %b", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s = %b, expected %b", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic fill_table();
        // Base pointer and two operands
        add_row(enc_i(OPI, 3'b000, 10, 0, 256), 32'h00, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_i(OPI, 3'b000, 1, 0, 1443), 32'h04, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_i(OPI, 3'b000, 2, 0, -240), 32'h08, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 1, 10, 0), 32'h0C, 1'b1, 32'h100, 32'h5A3, 4'hF, 1'b0);
        // ALU ops each shown by a sw
        add_row(enc_r(7'h00, 3'b000, 3, 1, 2), 32'h10, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 3, 10, 4), 32'h14, 1'b1, 32'h104, 32'h4B3, 4'hF, 1'b0);
        add_row(enc_r(7'h20, 3'b000, 4, 1, 2), 32'h18, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 4, 10, 8), 32'h1C, 1'b1, 32'h108, 32'h693, 4'hF, 1'b0);
        add_row(enc_r(7'h00, 3'b111, 5, 1, 2), 32'h20, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 5, 10, 12), 32'h24, 1'b1, 32'h10C, 32'h500, 4'hF, 1'b0);
        add_row(enc_r(7'h00, 3'b110, 6, 1, 2), 32'h28, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 6, 10, 16), 32'h2C, 1'b1, 32'h110, 32'hFFFFFFB3, 4'hF, 1'b0);
        add_row(enc_r(7'h00, 3'b100, 7, 1, 2), 32'h30, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 7, 10, 20), 32'h34, 1'b1, 32'h114, 32'hFFFFFAB3, 4'hF, 1'b0);
        add_row(enc_r(7'h00, 3'b010, 8, 2, 1), 32'h38, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 8, 10, 24), 32'h3C, 1'b1, 32'h118, 32'h1, 4'hF, 1'b0);
        add_row(enc_i(OPI, 3'b000, 9, 0, 4), 32'h40, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_r(7'h00, 3'b001, 11, 1, 9), 32'h44, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 11, 10, 28), 32'h48, 1'b1, 32'h11C, 32'h5A30, 4'hF, 1'b0);
        add_row(enc_r(7'h00, 3'b101, 12, 2, 9), 32'h4C, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 12, 10, 32), 32'h50, 1'b1, 32'h120, 32'h0FFFFFF1, 4'hF, 1'b0);
        // Sub-word stores with lanes replicated
        add_row(enc_s(F3_B, 1, 10, 0), 32'h54, 1'b1, 32'h100, 32'hA3A3A3A3, 4'h1, 1'b0);
        add_row(enc_s(F3_B, 1, 10, 1), 32'h58, 1'b1, 32'h101, 32'hA3A3A3A3, 4'h2, 1'b0);
        add_row(enc_s(F3_B, 1, 10, 2), 32'h5C, 1'b1, 32'h102, 32'hA3A3A3A3, 4'h4, 1'b0);
        add_row(enc_s(F3_B, 1, 10, 3), 32'h60, 1'b1, 32'h103, 32'hA3A3A3A3, 4'h8, 1'b0);
        add_row(enc_s(F3_H, 1, 10, 0), 32'h64, 1'b1, 32'h100, 32'h05A305A3, 4'h3, 1'b0);
        add_row(enc_s(F3_H, 1, 10, 2), 32'h68, 1'b1, 32'h102, 32'h05A305A3, 4'hC, 1'b0);
        // Loads each followed by a sw of x13
        add_row(enc_i(OPL, F3_W, 13, 10, 0), 32'h6C, 1'b0, 32'h100, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 13, 10, 36), 32'h70, 1'b1, 32'h124, 32'h0, 4'hF, 1'b1);
        add_row(enc_i(OPL, F3_H, 13, 10, 2), 32'h74, 1'b0, 32'h102, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 13, 10, 36), 32'h78, 1'b1, 32'h124, 32'h0, 4'hF, 1'b1);
        add_row(enc_i(OPL, F3_B, 13, 10, 3), 32'h7C, 1'b0, 32'h103, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 13, 10, 36), 32'h80, 1'b1, 32'h124, 32'h0, 4'hF, 1'b1);
        add_row(enc_i(OPL, F3_HU, 13, 10, 0), 32'h84, 1'b0, 32'h100, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 13, 10, 36), 32'h88, 1'b1, 32'h124, 32'h0, 4'hF, 1'b1);
        add_row(enc_i(OPL, F3_BU, 13, 10, 1), 32'h8C, 1'b0, 32'h101, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 13, 10, 36), 32'h90, 1'b1, 32'h124, 32'h0, 4'hF, 1'b1);
        // Custom-0 opcode aimed at x13 must leave it alone
        add_row(enc_i(7'b0001011, 3'b000, 13, 1, 1), 32'h94, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 13, 10, 36), 32'h98, 1'b1, 32'h124, 32'h0, 4'hF, 1'b1);
        // Branches taken then not taken
        add_row(enc_b(rv_isa_pkg::F3_BEQ, 1, 1, 8), 32'h9C, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_b(rv_isa_pkg::F3_BEQ, 1, 2, 8), 32'hA4, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_b(rv_isa_pkg::F3_BNE, 1, 2, 12), 32'hA8, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_b(rv_isa_pkg::F3_BNE, 1, 1, 8), 32'hB4, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_b(rv_isa_pkg::F3_BLT, 2, 1, 8), 32'hB8, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_b(rv_isa_pkg::F3_BLT, 1, 2, 8), 32'hC0, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_b(rv_isa_pkg::F3_BGE, 1, 2, 16), 32'hC4, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_b(rv_isa_pkg::F3_BGE, 2, 1, 8), 32'hD4, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        // jal forward with link, then backward with the link dropped in x0
        add_row(enc_j(14, 32), 32'hD8, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 14, 10, 40), 32'hF8, 1'b1, 32'h128, 32'hDC, 4'hF, 1'b0);
        add_row(enc_j(0, -64), 32'hFC, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(enc_s(F3_W, 0, 10, 44), 32'hBC, 1'b1, 32'h12C, 32'h0, 4'hF, 1'b0);
    endtask

    initial begin
        i_rst        <= 1'b1;
        i_instr      <= enc_s(F3_W, 1, 10, 0);   // A store held off by reset
        i_dmem_rdata <= 32'h0;
        fill_table();
        table_ready = 1'b1;
        @(posedge i_clk);
        @(negedge i_clk);
        check_word("o_pc", o_pc, 32'h0);
        check_bit("o_dmem_we", o_dmem_we, 1'b0);
        @(posedge i_clk);                          // Second reset edge
        i_rst <= 1'b0;
        for (int i = 0; i < tbl.size(); i++) begin
            draw_word(rd_word);
            i_instr      <= tbl[i].instr;
            i_dmem_rdata <= rd_word;
            is_load = (tbl[i].instr[6:0] == OPL);
            @(negedge i_clk);                      // Outputs settled
            check_word("o_pc", o_pc, tbl[i].pc);
            check_bit("o_dmem_we", o_dmem_we, tbl[i].we);
            if (tbl[i].we || is_load)
                check_word("o_dmem_addr", o_dmem_addr, tbl[i].addr);
            if (tbl[i].we) begin
                exp_wdata = tbl[i].from_load ? extend_load(ld_word, ld_f3, ld_off)
                                             : tbl[i].wdata;
                check_word("o_dmem_wdata", o_dmem_wdata, exp_wdata);
                check_be("o_dmem_be", o_dmem_be, tbl[i].be);
            end
            if (is_load) begin
                ld_word = rd_word;                 // Remember for the following sw
                ld_f3   = tbl[i].instr[14:12];
                ld_off  = tbl[i].addr[1:0];
            end
            @(posedge i_clk);
        end
        $display("Rows run: %0d, errors: %0d", tbl.size(), errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog sized by the table length
    initial begin
        wait (table_ready);
        #((tbl.size() + 10) * 100);
        $display("Timeout: the instruction table did not finish in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
